//--- compile.f
rtl/mips_addr_pkg.sv
rtl/axi_pkg.sv
rtl/reset_stretcher.sv
rtl/addr_translator.sv
rtl/fetch_axi_fsm.sv
rtl/fetch_top.sv
tb/fetch_properties.sv
tb/tb_fetch_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_fetch_top -f compile.f

# Keep running after an assertion error so that the testbench reports it.
out=$(./obj_dir/Vtb_fetch_top +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1

//--- tb/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;

    localparam int RST_HOLD_W     = 4;
    localparam int HOLD_CYCLES    = 1 << RST_HOLD_W;
    localparam int NUM_REQS       = 300;
    localparam int TIMEOUT_CYCLES = NUM_REQS * 30 + 100;

    logic                      aclk;
    logic                      aresetn;
    logic                      req_valid;
    mips_addr_pkg::vaddr_t     req_vaddr;
    logic                      kernel_mode;
    logic                      kseg0_cached;
    logic                      req_ready;
    logic                      resp_valid;
    mips_addr_pkg::word_t      resp_data;
    mips_addr_pkg::fetch_err_t resp_err;
    logic                      resp_ready;
    mips_addr_pkg::paddr_t     araddr;
    axi_pkg::axi_cache_t       arcache;
    logic                      arvalid;
    logic                      arready;
    mips_addr_pkg::word_t      rdata;
    axi_pkg::axi_resp_t        rresp;
    logic                      rvalid;
    logic                      rready;
    logic                      prop_failed;

    int seed        = 32'h6fcc;
    int cycle_count = 0;

    fetch_top #(
        .RST_HOLD_W(RST_HOLD_W)
    ) UUT (
        .i_aclk         (aclk),
        .i_aresetn      (aresetn),
        .i_req_valid    (req_valid),
        .i_req_vaddr    (req_vaddr),
        .i_kernel_mode  (kernel_mode),
        .i_kseg0_cached (kseg0_cached),
        .o_req_ready    (req_ready),
        .o_resp_valid   (resp_valid),
        .o_resp_data    (resp_data),
        .o_resp_err     (resp_err),
        .i_resp_ready   (resp_ready),
        .o_araddr       (araddr),
        .o_arcache      (arcache),
        .o_arvalid      (arvalid),
        .i_arready      (arready),
        .i_rdata        (rdata),
        .i_rresp        (rresp),
        .i_rvalid       (rvalid),
        .o_rready       (rready)
    );

    assign prop_failed = UUT.u_fetch_axi_fsm.u_fetch_properties.any_failed;

    always #50 aclk = ~aclk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_paddr(input string name, input mips_addr_pkg::paddr_t got,
                               input mips_addr_pkg::paddr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_cache(input string name, input axi_pkg::axi_cache_t got,
                               input axi_pkg::axi_cache_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input mips_addr_pkg::word_t got,
                              input mips_addr_pkg::word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_err(input string name, input mips_addr_pkg::fetch_err_t got,
                             input mips_addr_pkg::fetch_err_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    function automatic int pick_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    function automatic mips_addr_pkg::vaddr_t pick_vaddr();
        logic [31:0] r;
        int          seg;
        r   = $random(seed);
        seg = pick_below(4);
        case (seg)
            0: r[31] = 1'b0;
            1: r[31:29] = 3'b100;
            2: r[31:29] = 3'b101;
            default: r[31:30] = 2'b11;
        endcase
        // About one address in six keeps its random low bits.
        if (pick_below(6) != 0) begin
            r[1:0] = 2'b00;
        end
        return r;
    endfunction

    // The reference translation offsets kuseg and drops the top three bits in kseg0/1.
    function automatic mips_addr_pkg::paddr_t model_paddr(input mips_addr_pkg::vaddr_t va);
        mips_addr_pkg::paddr_t pa;
        if (!va[31]) begin
            pa = va + mips_addr_pkg::KUSEG_OFFSET;
        end else if (!va[30]) begin
            pa = {3'b000, va[28:0]};
        end else begin
            pa = va;
        end
        return pa;
    endfunction

    function automatic axi_pkg::axi_cache_t model_cache(input mips_addr_pkg::vaddr_t va,
                                                        input logic k0c);
        axi_pkg::axi_cache_t c;
        if (!va[31] || va[30]) begin
            c = axi_pkg::CACHE_WB;
        end else if (va[29]) begin
            c = axi_pkg::CACHE_DEV;
        end else begin
            c = k0c ? axi_pkg::CACHE_WB : axi_pkg::CACHE_DEV;
        end
        return c;
    endfunction

    function automatic logic model_addr_err(input mips_addr_pkg::vaddr_t va, input logic km);
        return (!km && va[31]) || (va[1:0] != 2'b00);
    endfunction

    // One request from acceptance to the taken response with the AXI slave model inline.
    task automatic run_fetch(input mips_addr_pkg::vaddr_t va, input logic km, input logic k0c);
        mips_addr_pkg::paddr_t     exp_paddr;
        axi_pkg::axi_cache_t       exp_cache;
        logic                      exp_adel;
        mips_addr_pkg::word_t      exp_data;
        mips_addr_pkg::fetch_err_t exp_err;
        axi_pkg::axi_resp_t        pick_resp;
        logic [1:0]                resp_bits;
        mips_addr_pkg::paddr_t     seen_addr;
        int                        ar_delay;
        int                        r_delay;
        int                        stall;
        int                        ar_wait;
        int                        r_wait;
        int                        stall_wait;
        int                        cyc;
        logic                      ar_seen;
        logic                      ar_done;
        logic                      r_done;
        logic                      resp_seen;
        logic                      taken;
        logic                      done;

        exp_paddr  = model_paddr(va);
        exp_cache  = model_cache(va, k0c);
        exp_adel   = model_addr_err(va, km);
        exp_data   = '0;
        exp_err    = mips_addr_pkg::FETCH_ADEL;
        seen_addr  = '0;
        ar_delay   = pick_below(6);
        r_delay    = pick_below(6);
        stall      = pick_below(4);
        resp_bits  = 2'(pick_below(4));
        pick_resp  = axi_pkg::axi_resp_t'(resp_bits);
        ar_wait    = 0;
        r_wait     = 0;
        stall_wait = 0;
        cyc        = 0;
        ar_seen    = 1'b0;
        ar_done    = 1'b0;
        r_done     = 1'b0;
        resp_seen  = 1'b0;
        taken      = 1'b0;
        done       = 1'b0;

        check_flag("o_req_ready", req_ready, 1'b1);
        req_valid    = 1'b1;
        req_vaddr    = va;
        kernel_mode  = km;
        kseg0_cached = k0c;
        @(posedge aclk);

        // req_valid stays high so that an early second acceptance would show.
        while (!done) begin
            @(negedge aclk);
            cyc        = cyc + 1;
            arready    = 1'b0;
            rvalid     = 1'b0;
            resp_ready = 1'b0;
            if (taken) begin
                check_flag("o_resp_valid", resp_valid, 1'b0);
                check_flag("o_req_ready", req_ready, 1'b1);
                req_valid = 1'b0;
                done      = 1'b1;
            end else begin
                check_flag("o_req_ready", req_ready, 1'b0);
                if (arvalid) begin
                    if (exp_adel || ar_done) begin
                        abort_run("an AXI read address was issued when none was expected");
                    end
                    if (!ar_seen && cyc != 2) begin
                        abort_run($sformatf("arvalid rose %0d cycles after acceptance, not 2",
                                            cyc));
                    end
                    ar_seen = 1'b1;
                    check_paddr("o_araddr", araddr, exp_paddr);
                    check_cache("o_arcache", arcache, exp_cache);
                    if (ar_wait == ar_delay) begin
                        arready   = 1'b1;
                        ar_done   = 1'b1;
                        seen_addr = araddr;
                    end else begin
                        ar_wait = ar_wait + 1;
                    end
                end
                if (rready && !r_done) begin
                    if (r_wait == r_delay) begin
                        rvalid   = 1'b1;
                        rdata    = seen_addr ^ 32'hA5A5_5A5A;
                        rresp    = pick_resp;
                        r_done   = 1'b1;
                        exp_data = exp_paddr ^ 32'hA5A5_5A5A;
                        if (pick_resp == axi_pkg::SLVERR || pick_resp == axi_pkg::DECERR) begin
                            exp_err = mips_addr_pkg::FETCH_BUS;
                        end else begin
                            exp_err = mips_addr_pkg::FETCH_OK;
                        end
                    end else begin
                        r_wait = r_wait + 1;
                    end
                end
                if (resp_valid) begin
                    if (!exp_adel && !r_done) begin
                        abort_run("a response arrived before the read data was returned");
                    end
                    if (exp_adel && !resp_seen && cyc != 2) begin
                        abort_run($sformatf("address error answered after %0d cycles, not 2",
                                            cyc));
                    end
                    resp_seen = 1'b1;
                    check_word("o_resp_data", resp_data, exp_data);
                    check_err("o_resp_err", resp_err, exp_err);
                    if (stall_wait == stall) begin
                        resp_ready = 1'b1;
                        taken      = 1'b1;
                    end else begin
                        stall_wait = stall_wait + 1;
                    end
                end
            end
        end
    endtask

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("the run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    always @(negedge aclk) begin
        if (prop_failed) begin
            abort_run("a protocol assertion on the fetch state machine failed");
        end
    end

    initial begin : stimulus
        int                    n;
        int                    gap;
        mips_addr_pkg::vaddr_t va;
        logic                  km;
        logic                  k0c;

        aclk         = 1'b0;
        aresetn      = 1'b0;
        req_valid    = 1'b0;
        req_vaddr    = '0;
        kernel_mode  = 1'b0;
        kseg0_cached = 1'b0;
        resp_ready   = 1'b0;
        arready      = 1'b0;
        rdata        = '0;
        rresp        = axi_pkg::OKAY;
        rvalid       = 1'b0;

        repeat (4) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        // Core stays in reset for the stretched period.
        for (n = 1; n <= HOLD_CYCLES; n++) begin
            @(negedge aclk);
            check_flag("o_req_ready", req_ready, n == HOLD_CYCLES);
            check_flag("o_arvalid", arvalid, 1'b0);
            check_flag("o_rready", rready, 1'b0);
            check_flag("o_resp_valid", resp_valid, 1'b0);
        end

        run_fetch(32'h0000_1000, 1'b0, 1'b0);
        run_fetch(32'h8000_2000, 1'b1, 1'b1);
        run_fetch(32'h8000_2004, 1'b1, 1'b0);
        run_fetch(32'hA000_3000, 1'b1, 1'b1);
        run_fetch(32'hC000_4000, 1'b1, 1'b0);
        run_fetch(32'hE000_5000, 1'b1, 1'b1);
        run_fetch(32'h0000_0002, 1'b1, 1'b0);
        run_fetch(32'h9000_0000, 1'b0, 1'b1);

        for (n = 8; n < NUM_REQS; n++) begin
            va  = pick_vaddr();
            km  = (pick_below(4) != 0);
            k0c = (pick_below(2) == 1);
            run_fetch(va, km, k0c);
            gap = pick_below(3);
            repeat (gap) @(negedge aclk);
        end

        @(negedge aclk);
        if (prop_failed) begin
            abort_run("a protocol assertion on the fetch state machine failed");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

//--- tb/fetch_properties.sv
`timescale 1ns/1ps

module fetch_properties (
    input logic                      i_aclk,
    input logic                      i_core_rst_n,
    input logic                      i_req_ready,
    input mips_addr_pkg::paddr_t     i_araddr,
    input logic                      i_arvalid,
    input logic                      i_arready,
    input logic                      i_rready,
    input logic                      i_resp_valid,
    input mips_addr_pkg::word_t      i_resp_data,
    input mips_addr_pkg::fetch_err_t i_resp_err,
    input logic                      i_resp_ready
);

    logic ar_hold_failed;
    logic resp_hold_failed;
    logic overlap_failed;
    logic ready_failed;
    logic any_failed;

    assign any_failed = ar_hold_failed | resp_hold_failed | overlap_failed | ready_failed;

    ar_held: assert property (@(posedge i_aclk) disable iff (!i_core_rst_n)
        i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
    else begin
        ar_hold_failed = 1'b1;
        $error("arvalid or araddr changed before arready");
    end

    resp_held: assert property (@(posedge i_aclk) disable iff (!i_core_rst_n)
        i_resp_valid && !i_resp_ready |=>
            i_resp_valid && $stable(i_resp_data) && $stable(i_resp_err))
    else begin
        resp_hold_failed = 1'b1;
        $error("response changed before i_resp_ready");
    end

    // Address and data phases never overlap for a single outstanding read.
    ar_r_apart: assert property (@(posedge i_aclk) disable iff (!i_core_rst_n)
        !(i_arvalid && i_rready))
    else begin
        overlap_failed = 1'b1;
        $error("arvalid and rready high together");
    end

    busy_while_resp: assert property (@(posedge i_aclk) disable iff (!i_core_rst_n)
        i_resp_valid |-> !i_req_ready)
    else begin
        ready_failed = 1'b1;
        $error("o_req_ready high while a response is pending");
    end

endmodule

bind fetch_axi_fsm fetch_properties u_fetch_properties (
    .i_aclk       (i_aclk),
    .i_core_rst_n (i_core_rst_n),
    .i_req_ready  (o_req_ready),
    .i_araddr     (o_araddr),
    .i_arvalid    (o_arvalid),
    .i_arready    (i_arready),
    .i_rready     (o_rready),
    .i_resp_valid (o_resp_valid),
    .i_resp_data  (o_resp_data),
    .i_resp_err   (o_resp_err),
    .i_resp_ready (i_resp_ready)
);

//--- rtl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter int RST_HOLD_W = 4
) (
    input  logic                      i_aclk,
    input  logic                      i_aresetn,

    input  logic                      i_req_valid,
    input  mips_addr_pkg::vaddr_t     i_req_vaddr,
    input  logic                      i_kernel_mode,
    input  logic                      i_kseg0_cached,
    output logic                      o_req_ready,

    output logic                      o_resp_valid,
    output mips_addr_pkg::word_t      o_resp_data,
    output mips_addr_pkg::fetch_err_t o_resp_err,
    input  logic                      i_resp_ready,

    output mips_addr_pkg::paddr_t     o_araddr,
    output axi_pkg::axi_cache_t       o_arcache,
    output logic                      o_arvalid,
    input  logic                      i_arready,

    input  mips_addr_pkg::word_t      i_rdata,
    input  axi_pkg::axi_resp_t        i_rresp,
    input  logic                      i_rvalid,
    output logic                      o_rready
);

    logic                  core_rst_n;
    logic                  xlate_en;
    mips_addr_pkg::paddr_t xlate_paddr;
    logic                  xlate_cached;
    logic                  xlate_err;

    reset_stretcher #(
        .RST_HOLD_W(RST_HOLD_W)
    ) u_reset_stretcher (
        .i_aclk       (i_aclk),
        .i_aresetn    (i_aresetn),
        .o_core_rst_n (core_rst_n)
    );

    addr_translator u_addr_translator (
        .i_aclk         (i_aclk),
        .i_core_rst_n   (core_rst_n),
        .i_xlate_en     (xlate_en),
        .i_vaddr        (i_req_vaddr),
        .i_kernel_mode  (i_kernel_mode),
        .i_kseg0_cached (i_kseg0_cached),
        .o_paddr        (xlate_paddr),
        .o_cached       (xlate_cached),
        .o_addr_err     (xlate_err)
    );

    fetch_axi_fsm u_fetch_axi_fsm (
        .i_aclk       (i_aclk),
        .i_core_rst_n (core_rst_n),
        .i_req_valid  (i_req_valid),
        .o_req_ready  (o_req_ready),
        .o_xlate_en   (xlate_en),
        .i_paddr      (xlate_paddr),
        .i_cached     (xlate_cached),
        .i_addr_err   (xlate_err),
        .o_araddr     (o_araddr),
        .o_arcache    (o_arcache),
        .o_arvalid    (o_arvalid),
        .i_arready    (i_arready),
        .i_rdata      (i_rdata),
        .i_rresp      (i_rresp),
        .i_rvalid     (i_rvalid),
        .o_rready     (o_rready),
        .o_resp_valid (o_resp_valid),
        .o_resp_data  (o_resp_data),
        .o_resp_err   (o_resp_err),
        .i_resp_ready (i_resp_ready)
    );

endmodule

//--- rtl/fetch_axi_fsm.sv
`timescale 1ns/1ps

module fetch_axi_fsm (
    input  logic                      i_aclk,
    input  logic                      i_core_rst_n,

    input  logic                      i_req_valid,
    output logic                      o_req_ready,
    output logic                      o_xlate_en,

    input  mips_addr_pkg::paddr_t     i_paddr,
    input  logic                      i_cached,
    input  logic                      i_addr_err,

    output mips_addr_pkg::paddr_t     o_araddr,
    output axi_pkg::axi_cache_t       o_arcache,
    output logic                      o_arvalid,
    input  logic                      i_arready,
    input  mips_addr_pkg::word_t      i_rdata,
    input  axi_pkg::axi_resp_t        i_rresp,
    input  logic                      i_rvalid,
    output logic                      o_rready,

    output logic                      o_resp_valid,
    output mips_addr_pkg::word_t      o_resp_data,
    output mips_addr_pkg::fetch_err_t o_resp_err,
    input  logic                      i_resp_ready
);

    typedef enum logic [2:0] {
        IDLE,
        XLATE,
        ADDR,
        DATA,
        RESP
    } state_t;

    state_t state;
    state_t state_next;
    logic   req_ready_q;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (i_req_valid && req_ready_q) begin
                    state_next = XLATE;
                end
            end
            XLATE: begin
                // Address errors skip the bus entirely.
                state_next = i_addr_err ? RESP : ADDR;
            end
            ADDR: begin
                if (i_arready) begin
                    state_next = DATA;
                end
            end
            DATA: begin
                if (i_rvalid) begin
                    state_next = RESP;
                end
            end
            RESP: begin
                if (i_resp_ready) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge i_aclk) begin
        if (!i_core_rst_n) begin
            state       <= IDLE;
            req_ready_q <= 1'b0;
        end else begin
            state       <= state_next;
            req_ready_q <= (state_next == IDLE);
        end
    end

    // Bus address and held response.
    always_ff @(posedge i_aclk) begin
        if (state == XLATE) begin
            if (i_addr_err) begin
                o_resp_data <= '0;
                o_resp_err  <= mips_addr_pkg::FETCH_ADEL;
            end else begin
                o_araddr  <= i_paddr;
                o_arcache <= i_cached ? axi_pkg::CACHE_WB : axi_pkg::CACHE_DEV;
            end
        end
        if (state == DATA && i_rvalid) begin
            o_resp_data <= i_rdata;
            o_resp_err  <= axi_pkg::is_err_resp(i_rresp) ? mips_addr_pkg::FETCH_BUS
                                                          : mips_addr_pkg::FETCH_OK;
        end
    end

    assign o_req_ready  = req_ready_q;
    assign o_xlate_en   = i_req_valid && req_ready_q;
    assign o_arvalid    = (state == ADDR);
    assign o_rready     = (state == DATA);
    assign o_resp_valid = (state == RESP);

endmodule

//--- rtl/addr_translator.sv
`timescale 1ns/1ps

module addr_translator (
    input  logic                  i_aclk,
    input  logic                  i_core_rst_n,
    input  logic                  i_xlate_en,
    input  mips_addr_pkg::vaddr_t i_vaddr,
    input  logic                  i_kernel_mode,
    input  logic                  i_kseg0_cached,
    output mips_addr_pkg::paddr_t o_paddr,
    output logic                  o_cached,
    output logic                  o_addr_err
);

    mips_addr_pkg::paddr_t paddr_d;
    logic                  cached_d;
    logic                  addr_err_d;

    // Segment decode on the upper address bits.
    always_comb begin
        if (i_vaddr < mips_addr_pkg::KSEG0_BASE) begin
            // kuseg
            paddr_d  = i_vaddr + mips_addr_pkg::KUSEG_OFFSET;
            cached_d = 1'b1;
        end else if (i_vaddr < mips_addr_pkg::KSEG1_BASE) begin
            // kseg0, cacheability from the config bit
            paddr_d  = i_vaddr & mips_addr_pkg::PHYS_MASK;
            cached_d = i_kseg0_cached;
        end else if (i_vaddr < mips_addr_pkg::KSEG2_BASE) begin
            // kseg1 is never cached
            paddr_d  = i_vaddr & mips_addr_pkg::PHYS_MASK;
            cached_d = 1'b0;
        end else begin
            paddr_d  = i_vaddr;
            cached_d = 1'b1;
        end
    end

    // Privilege check on kernel space and word alignment.
    assign addr_err_d = (!i_kernel_mode && i_vaddr[31]) || (i_vaddr[1:0] != 2'b00);

    always_ff @(posedge i_aclk) begin
        if (!i_core_rst_n) begin
            o_cached   <= 1'b0;
            o_addr_err <= 1'b0;
        end else if (i_xlate_en) begin
            o_cached   <= cached_d;
            o_addr_err <= addr_err_d;
        end
    end

    always_ff @(posedge i_aclk) begin
        if (i_xlate_en) begin
            o_paddr <= paddr_d;
        end
    end

endmodule

//--- rtl/reset_stretcher.sv
`timescale 1ns/1ps

module reset_stretcher #(
    parameter int RST_HOLD_W = 4
) (
    input  logic i_aclk,
    input  logic i_aresetn,
    output logic o_core_rst_n
);

    logic [RST_HOLD_W-1:0] hold_cnt;
    logic [RST_HOLD_W-1:0] hold_cnt_inc;
    logic                  core_rst_n_q;

    assign hold_cnt_inc = hold_cnt + 1'b1;

    // Count while the core is held; release on the edge the counter saturates.
    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            hold_cnt     <= '0;
            core_rst_n_q <= 1'b0;
        end else if (!core_rst_n_q) begin
            hold_cnt <= hold_cnt_inc;
            if (&hold_cnt_inc) begin
                core_rst_n_q <= 1'b1;
            end
        end
    end

    assign o_core_rst_n = core_rst_n_q;

endmodule

//--- rtl/axi_pkg.sv
package axi_pkg;

    // Read response codes.
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

    // Cache attribute carried on arcache.
    typedef logic [3:0] axi_cache_t;

    // Cacheable write-back, read and write allocate.
    localparam axi_cache_t CACHE_WB = 4'b1111;

    // Device, non-bufferable.
    localparam axi_cache_t CACHE_DEV = 4'b0000;

    // SLVERR and DECERR both end a transfer with an error.
    function automatic logic is_err_resp(input axi_resp_t resp);
        logic err;
        err = (resp == SLVERR) || (resp == DECERR);
        return err;
    endfunction

endpackage

//--- rtl/mips_addr_pkg.sv
package mips_addr_pkg;

    // Data word returned by an instruction fetch.
    typedef logic [31:0] word_t;

    // Virtual address as issued by the fetch stage.
    typedef logic [31:0] vaddr_t;

    // Physical address as seen on the AXI bus.
    typedef logic [31:0] paddr_t;

    // Result of one fetch.
    typedef enum logic [1:0] {
        FETCH_OK   = 2'd0,
        FETCH_ADEL = 2'd1,
        FETCH_BUS  = 2'd2
    } fetch_err_t;

    // Lower bounds of the kernel segments.
    localparam vaddr_t KSEG0_BASE = 32'h8000_0000;
    localparam vaddr_t KSEG1_BASE = 32'hA000_0000;
    localparam vaddr_t KSEG2_BASE = 32'hC000_0000;

    // Unmapped kernel segments drop the top three bits.
    localparam paddr_t PHYS_MASK = 32'h1FFF_FFFF;

    // Fixed offset applied to user segment addresses.
    localparam paddr_t KUSEG_OFFSET = 32'h4000_0000;

endpackage
